// ==== hdl/lsq_mem_pkg.sv ====
package lsq_mem_pkg;

  // Doubleword address, the byte address without its three low bits
  localparam int WORD_ADDR_W = 29;
  localparam int DATA_W      = 64;

  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [DATA_W-1:0]      data_t;

  // Load read port, the cache answers in the same cycle
  typedef struct packed {
    logic       rd_en;
    word_addr_t addr;
  } cache_rd_req_t;

  // Store write port, held until the cache acknowledges
  typedef struct packed {
    logic       wr_en;
    word_addr_t addr;
    data_t      data;
  } cache_wr_req_t;

endpackage

// ==== hdl/lsq_ctrl_pkg.sv ====
package lsq_ctrl_pkg;

  import lsq_mem_pkg::*;

  // Superscalar width of the core
  localparam int NUM_SLOTS = 2;
  localparam int TAG_W     = 6;
  localparam int PC_W      = 32;
  // Queue indices travel at full width, rings use the low bits
  localparam int IDX_W     = 8;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [PC_W-1:0]  pc_t;
  typedef logic [IDX_W-1:0] idx_t;

  typedef enum logic [1:0] {
    slot_none,
    slot_load,
    slot_store
  } slot_op_e;

  typedef struct packed {
    slot_op_e op;
    pc_t      pc;
  } dispatch_t;

  typedef struct packed {
    logic       valid;
    idx_t       sq_idx;
    word_addr_t addr;
    data_t      data;
  } store_exec_t;

  typedef struct packed {
    logic       valid;
    idx_t       lq_idx;
    word_addr_t addr;
    tag_t       tag;
  } load_exec_t;

  typedef struct packed {
    logic  done;
    tag_t  tag;
    data_t data;
    logic  forwarded;
  } load_result_t;

  typedef struct packed {
    logic valid;
    idx_t lq_idx;
    pc_t  pc;
  } violation_t;

  // Executing store as seen by the load ring
  typedef struct packed {
    logic       valid;
    word_addr_t addr;
    idx_t       sq_idx;
    idx_t       sq_head;
  } store_probe_t;

  typedef struct packed {
    logic       valid;
    word_addr_t addr;
    data_t      data;
  } sq_entry_t;

  // bound is the sq index of the first store younger than the load
  typedef struct packed {
    pc_t        pc;
    idx_t       bound;
    word_addr_t addr;
    logic       executed;
  } lq_entry_t;

endpackage

// ==== hdl/store_forward.sv ====
`timescale 1ns/1ns

module store_forward
  import lsq_mem_pkg::*, lsq_ctrl_pkg::*;
#(
  parameter int LSQ_DEPTH = 8
) (
  input  sq_entry_t [LSQ_DEPTH-1:0] entries,
  input  idx_t                      sq_head,
  input  word_addr_t                fwd_addr,
  input  idx_t                      fwd_bound,
  output logic                      fwd_hit,
  output data_t                     fwd_data
);

  localparam int PTR_W = $clog2(LSQ_DEPTH);

  logic [PTR_W-1:0] bound_rank;

  // Stores ranked below the boundary are older than the load
  assign bound_rank = fwd_bound[PTR_W-1:0] - sq_head[PTR_W-1:0];

  // Walk oldest to youngest, the last match is the youngest older store
  always_comb begin
    logic [PTR_W-1:0] idx;
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int j = 0; j < LSQ_DEPTH; j++) begin
      idx = sq_head[PTR_W-1:0] + PTR_W'(j);
      if (PTR_W'(j) < bound_rank && entries[idx].valid &&
          entries[idx].addr == fwd_addr) begin
        fwd_hit  = 1'b1;
        fwd_data = entries[idx].data;
      end
    end
  end

endmodule

// ==== hdl/store_queue.sv ====
`timescale 1ns/1ns

module store_queue
  import lsq_mem_pkg::*, lsq_ctrl_pkg::*;
#(
  parameter int LSQ_DEPTH = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  dispatch_t [NUM_SLOTS-1:0] dispatch,
  input  logic                      dispatch_fire,
  input  store_exec_t               store_exec,
  input  word_addr_t                fwd_addr,
  input  idx_t                      fwd_bound,
  input  logic                      store_retire,
  input  logic                      cache_wr_ack,
  output logic                      sq_ready,
  output idx_t [NUM_SLOTS-1:0]      sq_idx,
  output idx_t [NUM_SLOTS-1:0]      slot_bound,
  output logic                      fwd_hit,
  output data_t                     fwd_data,
  output store_probe_t              store_probe,
  output cache_wr_req_t             cache_wr,
  output logic                      store_retired
);

  localparam int PTR_W = $clog2(LSQ_DEPTH);

  logic [PTR_W-1:0]                head;
  logic [PTR_W-1:0]                tail;
  logic [PTR_W-1:0]                count;
  logic [PTR_W:0]                  free_slots;
  logic [1:0]                      need;
  logic [NUM_SLOTS-1:0][PTR_W-1:0] slot_ptr;
  logic [PTR_W-1:0]                exec_ptr;
  logic [PTR_W-1:0]                exec_rank;
  logic [LSQ_DEPTH-1:0]            addr_valid;
  word_addr_t                      addr_mem [LSQ_DEPTH];
  data_t                           data_mem [LSQ_DEPTH];
  sq_entry_t [LSQ_DEPTH-1:0]       entries;

  // One slot stays empty so head == tail means empty
  assign count      = tail - head;
  assign free_slots = (PTR_W+1)'(LSQ_DEPTH - 1) - {1'b0, count};

  // Stores take consecutive slots from the tail in bundle order
  always_comb begin
    need = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_ptr[i] = tail + PTR_W'(need);
      sq_idx[i]   = idx_t'(slot_ptr[i]);
      if (dispatch[i].op == slot_store) begin
        need = need + 2'd1;
      end
    end
  end

  assign sq_ready = (PTR_W+1)'(need) <= free_slots;

  // A load's boundary is the index the next store in its slot would take
  assign slot_bound = sq_idx;

  assign exec_ptr  = store_exec.sq_idx[PTR_W-1:0];
  assign exec_rank = exec_ptr - head;

  // Head store goes to the cache once its address is known
  assign cache_wr.wr_en = store_retire & addr_valid[head];
  assign cache_wr.addr  = addr_mem[head];
  assign cache_wr.data  = data_mem[head];
  assign store_retired  = cache_wr.wr_en & cache_wr_ack;

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      addr_valid <= '0;
    end else begin
      if (dispatch_fire) begin
        tail <= tail + PTR_W'(need);
      end
      if (store_retired) begin
        head             <= head + 1'b1;
        addr_valid[head] <= 1'b0;
      end
      if (dispatch_fire) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
          if (dispatch[i].op == slot_store) begin
            addr_valid[slot_ptr[i]] <= 1'b0;
          end
        end
      end
      if (store_exec.valid) begin
        addr_valid[exec_ptr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store_exec.valid) begin
      addr_mem[exec_ptr] <= store_exec.addr;
      data_mem[exec_ptr] <= store_exec.data;
    end
  end

  always_comb begin
    for (int i = 0; i < LSQ_DEPTH; i++) begin
      entries[i].valid = addr_valid[i];
      entries[i].addr  = addr_mem[i];
      entries[i].data  = data_mem[i];
    end
  end

  assign store_probe.valid   = store_exec.valid;
  assign store_probe.addr    = store_exec.addr;
  assign store_probe.sq_idx  = idx_t'(exec_ptr);
  assign store_probe.sq_head = idx_t'(head);

  store_forward #(
    .LSQ_DEPTH (LSQ_DEPTH)
  ) u_store_forward (
    .entries   (entries),
    .sq_head   (idx_t'(head)),
    .fwd_addr  (fwd_addr),
    .fwd_bound (fwd_bound),
    .fwd_hit   (fwd_hit),
    .fwd_data  (fwd_data)
  );

  a_exec_allocated: assert property (@(posedge clock) disable iff (reset)
    store_exec.valid |-> exec_rank < count);

  // Retire clears the head entry, so an empty ring never has an address
  a_no_write_when_empty: assert property (@(posedge clock) disable iff (reset)
    cache_wr.wr_en |-> count != '0);

endmodule

// ==== hdl/load_order_check.sv ====
`timescale 1ns/1ns

module load_order_check
  import lsq_ctrl_pkg::*;
#(
  parameter int LSQ_DEPTH = 8
) (
  input  lq_entry_t [LSQ_DEPTH-1:0] entries,
  input  idx_t                      lq_head,
  input  store_probe_t              store_probe,
  output logic                      hit,
  output idx_t                      hit_idx
);

  localparam int PTR_W = $clog2(LSQ_DEPTH);

  logic [PTR_W-1:0] store_rank;

  // Ranks are distances from the store head
  assign store_rank = store_probe.sq_idx[PTR_W-1:0] - store_probe.sq_head[PTR_W-1:0];

  // Walk youngest to oldest so the oldest matching load is kept
  always_comb begin
    logic [PTR_W-1:0] idx;
    logic [PTR_W-1:0] bound_rank;
    hit     = 1'b0;
    hit_idx = '0;
    for (int j = LSQ_DEPTH - 1; j >= 0; j--) begin
      idx        = lq_head[PTR_W-1:0] + PTR_W'(j);
      bound_rank = entries[idx].bound[PTR_W-1:0] - store_probe.sq_head[PTR_W-1:0];
      // Store older than the load whose data was already taken
      if (store_probe.valid && entries[idx].executed &&
          entries[idx].addr == store_probe.addr && bound_rank > store_rank) begin
        hit     = 1'b1;
        hit_idx = idx_t'(idx);
      end
    end
  end

endmodule

// ==== hdl/load_queue.sv ====
`timescale 1ns/1ns

module load_queue
  import lsq_mem_pkg::*, lsq_ctrl_pkg::*;
#(
  parameter int LSQ_DEPTH = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  dispatch_t [NUM_SLOTS-1:0] dispatch,
  input  logic                      dispatch_fire,
  input  idx_t [NUM_SLOTS-1:0]      slot_bound,
  input  load_exec_t                load_exec,
  input  logic                      fwd_hit,
  input  data_t                     fwd_data,
  input  logic                      cache_rd_valid,
  input  data_t                     cache_rd_data,
  input  store_probe_t              store_probe,
  input  logic [1:0]                load_retire_count,
  output logic                      lq_ready,
  output idx_t [NUM_SLOTS-1:0]      lq_idx,
  output word_addr_t                fwd_addr,
  output idx_t                      fwd_bound,
  output cache_rd_req_t             cache_rd,
  output load_result_t              load_result,
  output violation_t                violation
);

  localparam int PTR_W = $clog2(LSQ_DEPTH);

  logic [PTR_W-1:0]                head;
  logic [PTR_W-1:0]                tail;
  logic [PTR_W-1:0]                count;
  logic [PTR_W:0]                  free_slots;
  logic [1:0]                      need;
  logic [NUM_SLOTS-1:0][PTR_W-1:0] slot_ptr;
  logic [PTR_W-1:0]                exec_ptr;
  logic                            exec_done;
  logic [LSQ_DEPTH-1:0]            executed;
  pc_t                             pc_mem [LSQ_DEPTH];
  idx_t                            bound_mem [LSQ_DEPTH];
  word_addr_t                      addr_mem [LSQ_DEPTH];
  lq_entry_t [LSQ_DEPTH-1:0]       entries;
  logic                            order_hit;
  idx_t                            order_idx;
  logic                            res_done;
  tag_t                            res_tag;
  data_t                           res_data;
  logic                            res_fwd;
  logic                            viol_valid;
  idx_t                            viol_idx;
  pc_t                             viol_pc;

  assign count      = tail - head;
  assign free_slots = (PTR_W+1)'(LSQ_DEPTH - 1) - {1'b0, count};

  always_comb begin
    need = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_ptr[i] = tail + PTR_W'(need);
      lq_idx[i]   = idx_t'(slot_ptr[i]);
      if (dispatch[i].op == slot_load) begin
        need = need + 2'd1;
      end
    end
  end

  assign lq_ready = (PTR_W+1)'(need) <= free_slots;

  // Forward query uses the store boundary recorded at dispatch
  assign exec_ptr  = load_exec.lq_idx[PTR_W-1:0];
  assign fwd_addr  = load_exec.addr;
  assign fwd_bound = bound_mem[exec_ptr];

  assign cache_rd.rd_en = load_exec.valid & ~fwd_hit;
  assign cache_rd.addr  = load_exec.addr;

  // Without data the load stays unexecuted and must be issued again
  assign exec_done = load_exec.valid & (fwd_hit | (cache_rd.rd_en & cache_rd_valid));

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      executed   <= '0;
      res_done   <= 1'b0;
      viol_valid <= 1'b0;
    end else begin
      res_done   <= exec_done;
      viol_valid <= order_hit;
      head       <= head + PTR_W'(load_retire_count);
      for (int k = 0; k < NUM_SLOTS; k++) begin
        if (k < int'(load_retire_count)) begin
          executed[head + PTR_W'(k)] <= 1'b0;
        end
      end
      if (dispatch_fire) begin
        tail <= tail + PTR_W'(need);
        for (int i = 0; i < NUM_SLOTS; i++) begin
          if (dispatch[i].op == slot_load) begin
            executed[slot_ptr[i]] <= 1'b0;
          end
        end
      end
      if (exec_done) begin
        executed[exec_ptr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (dispatch[i].op == slot_load) begin
          pc_mem[slot_ptr[i]]    <= dispatch[i].pc;
          bound_mem[slot_ptr[i]] <= slot_bound[i];
        end
      end
    end
    if (load_exec.valid) begin
      addr_mem[exec_ptr] <= load_exec.addr;
      res_tag            <= load_exec.tag;
      res_data           <= fwd_hit ? fwd_data : cache_rd_data;
      res_fwd            <= fwd_hit;
    end
    if (order_hit) begin
      viol_idx <= order_idx;
      viol_pc  <= entries[order_idx[PTR_W-1:0]].pc;
    end
  end

  always_comb begin
    for (int i = 0; i < LSQ_DEPTH; i++) begin
      entries[i].pc       = pc_mem[i];
      entries[i].bound    = bound_mem[i];
      entries[i].addr     = addr_mem[i];
      entries[i].executed = executed[i];
    end
  end

  assign load_result = '{done: res_done, tag: res_tag, data: res_data, forwarded: res_fwd};
  assign violation   = '{valid: viol_valid, lq_idx: viol_idx, pc: viol_pc};

  load_order_check #(
    .LSQ_DEPTH (LSQ_DEPTH)
  ) u_load_order_check (
    .entries     (entries),
    .lq_head     (idx_t'(head)),
    .store_probe (store_probe),
    .hit         (order_hit),
    .hit_idx     (order_idx)
  );

  a_retire_occupied: assert property (@(posedge clock) disable iff (reset)
    (PTR_W+1)'(load_retire_count) <= {1'b0, count});

endmodule

// ==== hdl/lsq_top.sv ====
`timescale 1ns/1ns

module lsq_top
  import lsq_mem_pkg::*, lsq_ctrl_pkg::*;
#(
  parameter int LSQ_DEPTH = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  dispatch_t [NUM_SLOTS-1:0] dispatch,
  input  logic                      dispatch_en,
  input  store_exec_t               store_exec,
  input  load_exec_t                load_exec,
  input  logic                      store_retire,
  input  logic [1:0]                load_retire_count,
  input  logic                      cache_rd_valid,
  input  data_t                     cache_rd_data,
  input  logic                      cache_wr_ack,
  output logic                      dispatch_ready,
  output idx_t [NUM_SLOTS-1:0]      sq_idx,
  output idx_t [NUM_SLOTS-1:0]      lq_idx,
  output cache_rd_req_t             cache_rd,
  output cache_wr_req_t             cache_wr,
  output logic                      store_retired,
  output load_result_t              load_result,
  output violation_t                violation
);

  logic                 sq_ready;
  logic                 lq_ready;
  logic                 dispatch_fire;
  idx_t [NUM_SLOTS-1:0] slot_bound;
  word_addr_t           fwd_addr;
  idx_t                 fwd_bound;
  logic                 fwd_hit;
  data_t                fwd_data;
  store_probe_t         store_probe;

  // A bundle goes in only when both rings have room
  assign dispatch_ready = sq_ready & lq_ready;
  assign dispatch_fire  = dispatch_en & dispatch_ready;

  store_queue #(
    .LSQ_DEPTH (LSQ_DEPTH)
  ) u_store_queue (
    .clock         (clock),
    .reset         (reset),
    .dispatch      (dispatch),
    .dispatch_fire (dispatch_fire),
    .store_exec    (store_exec),
    .fwd_addr      (fwd_addr),
    .fwd_bound     (fwd_bound),
    .store_retire  (store_retire),
    .cache_wr_ack  (cache_wr_ack),
    .sq_ready      (sq_ready),
    .sq_idx        (sq_idx),
    .slot_bound    (slot_bound),
    .fwd_hit       (fwd_hit),
    .fwd_data      (fwd_data),
    .store_probe   (store_probe),
    .cache_wr      (cache_wr),
    .store_retired (store_retired)
  );

  load_queue #(
    .LSQ_DEPTH (LSQ_DEPTH)
  ) u_load_queue (
    .clock             (clock),
    .reset             (reset),
    .dispatch          (dispatch),
    .dispatch_fire     (dispatch_fire),
    .slot_bound        (slot_bound),
    .load_exec         (load_exec),
    .fwd_hit           (fwd_hit),
    .fwd_data          (fwd_data),
    .cache_rd_valid    (cache_rd_valid),
    .cache_rd_data     (cache_rd_data),
    .store_probe       (store_probe),
    .load_retire_count (load_retire_count),
    .lq_ready          (lq_ready),
    .lq_idx            (lq_idx),
    .fwd_addr          (fwd_addr),
    .fwd_bound         (fwd_bound),
    .cache_rd          (cache_rd),
    .load_result       (load_result),
    .violation         (violation)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Released on a falling edge, away from the active edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// ==== testbench/lsq_tests.svh ====
task automatic check_slot_indices(input slot_op_e ops [NUM_SLOTS],
                                  input idx_t exp_idx [NUM_SLOTS]);
  for (int i = 0; i < NUM_SLOTS; i++) begin
    if (ops[i] == slot_store) begin
      check_index(sq_idx[i], exp_idx[i], $sformatf("sq_idx of slot %0d", i));
    end else if (ops[i] == slot_load) begin
      check_index(lq_idx[i], exp_idx[i], $sformatf("lq_idx of slot %0d", i));
    end
  end
endtask

// Ready and indices follow from the ring model, a blocked bundle is held one cycle
task automatic dispatch_bundle(input slot_op_e op0, input pc_t pc0, input slot_op_e op1,
                               input pc_t pc1, output idx_t idx0, output idx_t idx1);
  slot_op_e ops [NUM_SLOTS];
  idx_t     exp_idx [NUM_SLOTS];
  int       sq_need;
  int       lq_need;
  logic     exp_ready;
  ops[0]  = op0;
  ops[1]  = op1;
  sq_need = 0;
  lq_need = 0;
  for (int i = 0; i < NUM_SLOTS; i++) begin
    exp_idx[i] = '0;
    if (ops[i] == slot_store) begin
      exp_idx[i] = idx_t'((sq_tail_m + sq_need) % LSQ_DEPTH);
      sq_need++;
    end else if (ops[i] == slot_load) begin
      exp_idx[i] = idx_t'((lq_tail_m + lq_need) % LSQ_DEPTH);
      lq_need++;
    end
  end
  exp_ready = (sq_need <= LSQ_DEPTH - 1 - ring_count(sq_head_m, sq_tail_m)) &&
              (lq_need <= LSQ_DEPTH - 1 - ring_count(lq_head_m, lq_tail_m));
  @(negedge clock);
  dispatch[0] = '{op: op0, pc: pc0};
  dispatch[1] = '{op: op1, pc: pc1};
  dispatch_en = 1'b1;
  #2;
  check_level(dispatch_ready, exp_ready, "dispatch_ready");
  check_slot_indices(ops, exp_idx);
  @(negedge clock);
  if (!exp_ready) begin
    check_slot_indices(ops, exp_idx);
  end
  dispatch_en = 1'b0;
  dispatch    = '0;
  if (exp_ready) begin
    sq_tail_m = (sq_tail_m + sq_need) % LSQ_DEPTH;
    lq_tail_m = (lq_tail_m + lq_need) % LSQ_DEPTH;
  end
  idx0 = exp_idx[0];
  idx1 = exp_idx[1];
endtask

task automatic exec_store(input idx_t idx, input word_addr_t addr, input data_t data,
                          input violation_t exp_viol);
  @(negedge clock);
  store_exec = '{valid: 1'b1, sq_idx: idx, addr: addr, data: data};
  @(negedge clock);
  check_violation(violation, exp_viol);
  store_exec.valid = 1'b0;
  sq_addr_m[int'(idx) % LSQ_DEPTH] = addr;
  sq_data_m[int'(idx) % LSQ_DEPTH] = data;
endtask

task automatic exec_load(input idx_t idx, input word_addr_t addr, input tag_t tag,
                         input logic cache_ok, input logic exp_fwd, input data_t fwd_data);
  cache_rd_req_t exp_rd;
  load_result_t  exp_res;
  exp_rd  = '{rd_en: !exp_fwd, addr: addr};
  exp_res = '{done: exp_fwd | cache_ok, tag: tag,
              data: exp_fwd ? fwd_data : cache_mem[addr[3:0]], forwarded: exp_fwd};
  @(negedge clock);
  cache_ready = cache_ok;
  load_exec   = '{valid: 1'b1, lq_idx: idx, addr: addr, tag: tag};
  #2;
  check_cache_rd(cache_rd, exp_rd);
  @(negedge clock);
  check_load_result(load_result, exp_res);
  load_exec.valid = 1'b0;
  cache_ready     = 1'b0;
endtask

// Holds the request for ack_wait cycles before the acknowledge
task automatic retire_store(input int ack_wait);
  cache_wr_req_t exp_wr;
  exp_wr = '{wr_en: 1'b1, addr: sq_addr_m[sq_head_m], data: sq_data_m[sq_head_m]};
  @(negedge clock);
  store_retire = 1'b1;
  cache_wr_ack = 1'b0;
  repeat (ack_wait) begin
    #2;
    check_cache_wr(cache_wr, exp_wr);
    check_level(store_retired, 1'b0, "store_retired without ack");
    @(negedge clock);
  end
  cache_wr_ack = 1'b1;
  #2;
  check_cache_wr(cache_wr, exp_wr);
  check_level(store_retired, 1'b1, "store_retired with ack");
  @(negedge clock);
  store_retire = 1'b0;
  cache_wr_ack = 1'b0;
  sq_head_m    = (sq_head_m + 1) % LSQ_DEPTH;
endtask

task automatic retire_loads(input int n);
  @(negedge clock);
  load_retire_count = 2'(n);
  @(negedge clock);
  load_retire_count = '0;
  lq_head_m         = (lq_head_m + n) % LSQ_DEPTH;
endtask

task automatic dispatch_and_fill_rings();
  idx_t a;
  idx_t b;
  @(negedge clock);
  #2;
  check_level(cache_rd.rd_en, 1'b0, "cache_rd.rd_en after reset");
  check_level(cache_wr.wr_en, 1'b0, "cache_wr.wr_en after reset");
  check_level(store_retired, 1'b0, "store_retired after reset");
  check_level(load_result.done, 1'b0, "load_result.done after reset");
  check_level(violation.valid, 1'b0, "violation.valid after reset");
  check_level(dispatch_ready, 1'b1, "dispatch_ready after reset");
  for (int i = 0; i < 3; i++) begin
    dispatch_bundle(slot_load, pc_t'(32'h1000 + 8 * i), slot_store, pc_t'(32'h1004 + 8 * i),
                    a, b);
  end
  dispatch_bundle(slot_store, 32'h1100, slot_store, 32'h1104, a, b);
  dispatch_bundle(slot_store, 32'h1108, slot_store, 32'h110c, a, b);
  // Store ring is full, only a bundle without stores goes in
  dispatch_bundle(slot_load, 32'h1110, slot_store, 32'h1114, a, b);
  dispatch_bundle(slot_store, 32'h1118, slot_none, '0, a, b);
  dispatch_bundle(slot_load, 32'h1120, slot_load, 32'h1124, a, b);
  for (int i = 0; i < LSQ_DEPTH - 1; i++) begin
    exec_store(idx_t'(i), word_addr_t'(32'h100 + i), {32'hbeef_0000, 32'(i)}, '0);
  end
  repeat (LSQ_DEPTH - 1) retire_store(0);
  retire_loads(2);
  retire_loads(2);
  retire_loads(1);
endtask

task automatic forward_from_older_store();
  idx_t s_old;
  idx_t s_mid;
  idx_t ld;
  idx_t s_young;
  dispatch_bundle(slot_store, 32'h2000, slot_store, 32'h2004, s_old, s_mid);
  dispatch_bundle(slot_load, 32'h2008, slot_store, 32'h200c, ld, s_young);
  exec_store(s_old, 29'h0a0, 64'h1111_2222_3333_4444, '0);
  exec_store(s_mid, 29'h0a0, 64'h5555_6666_7777_8888, '0);
  // Younger than the load, so never a forward source
  exec_store(s_young, 29'h0a0, 64'h9999_aaaa_bbbb_cccc, '0);
  exec_load(ld, 29'h0a0, 6'h21, 1'b1, 1'b1, 64'h5555_6666_7777_8888);
  repeat (3) retire_store(0);
  retire_loads(1);
endtask

task automatic read_through_cache();
  idx_t l0;
  idx_t l1;
  idx_t s0;
  idx_t l2;
  dispatch_bundle(slot_load, 32'h3000, slot_load, 32'h3004, l0, l1);
  exec_load(l0, 29'h005, 6'h05, 1'b1, 1'b0, '0);
  // No cache data, so the load is issued again
  exec_load(l1, 29'h01a, 6'h06, 1'b0, 1'b0, '0);
  exec_load(l1, 29'h01a, 6'h06, 1'b1, 1'b0, '0);
  dispatch_bundle(slot_store, 32'h3008, slot_load, 32'h300c, s0, l2);
  exec_store(s0, 29'h040, 64'h0123_4567_89ab_cdef, '0);
  exec_load(l2, 29'h003, 6'h07, 1'b1, 1'b0, '0);
  retire_store(0);
  retire_loads(2);
  retire_loads(1);
endtask

task automatic retire_stores_in_order();
  idx_t s0;
  idx_t s1;
  idx_t s2;
  idx_t unused;
  dispatch_bundle(slot_store, 32'h4000, slot_store, 32'h4004, s0, s1);
  dispatch_bundle(slot_store, 32'h4008, slot_none, '0, s2, unused);
  // Head store has no address yet
  @(negedge clock);
  store_retire = 1'b1;
  cache_wr_ack = 1'b1;
  #2;
  check_level(cache_wr.wr_en, 1'b0, "cache_wr.wr_en before head executes");
  check_level(store_retired, 1'b0, "store_retired before head executes");
  @(negedge clock);
  store_retire = 1'b0;
  cache_wr_ack = 1'b0;
  exec_store(s2, 29'h0c2, 64'hc2c2_0000_0000_0002, '0);
  exec_store(s0, 29'h0c0, 64'hc0c0_0000_0000_0000, '0);
  exec_store(s1, 29'h0c1, 64'hc1c1_0000_0000_0001, '0);
  retire_store(3);
  retire_store(0);
  retire_store(1);
endtask

task automatic flag_ordering_violation();
  idx_t       sa;
  idx_t       sb;
  idx_t       ld;
  idx_t       unused;
  violation_t exp_viol;
  dispatch_bundle(slot_store, 32'h5000, slot_store, 32'h5004, sa, sb);
  dispatch_bundle(slot_load, 32'h5008, slot_none, '0, ld, unused);
  exec_load(ld, 29'h077, 6'h09, 1'b1, 1'b0, '0);
  // Older store to another word
  exec_store(sa, 29'h078, 64'hdead_0000_0000_0078, '0);
  exp_viol = '{valid: 1'b1, lq_idx: ld, pc: 32'h5008};
  exec_store(sb, 29'h077, 64'hdead_0000_0000_0077, exp_viol);
  repeat (2) retire_store(0);
  retire_loads(1);
endtask

// ==== testbench/lsq_tb.sv ====
`timescale 1ns/1ns

module lsq_tb
  import lsq_mem_pkg::*, lsq_ctrl_pkg::*;
();

  localparam int          LSQ_DEPTH   = 8;
  localparam int          CACHE_WORDS = 16;
  localparam logic [31:0] SEED        = 32'h54f2_1fee;
  // The whole run takes about 150 cycles
  localparam int          TIMEOUT_CYCLES = 400;

  logic                      clock;
  logic                      reset;
  dispatch_t [NUM_SLOTS-1:0] dispatch;
  logic                      dispatch_en;
  store_exec_t               store_exec;
  load_exec_t                load_exec;
  logic                      store_retire;
  logic [1:0]                load_retire_count;
  logic                      cache_rd_valid;
  data_t                     cache_rd_data;
  logic                      cache_wr_ack;
  logic                      dispatch_ready;
  idx_t [NUM_SLOTS-1:0]      sq_idx;
  idx_t [NUM_SLOTS-1:0]      lq_idx;
  cache_rd_req_t             cache_rd;
  cache_wr_req_t             cache_wr;
  logic                      store_retired;
  load_result_t              load_result;
  violation_t                violation;

  data_t      cache_mem [CACHE_WORDS];
  logic       cache_ready;
  int         cycle_count = 0;

  // Expected ring pointers and executed store contents
  int         sq_head_m;
  int         sq_tail_m;
  int         lq_head_m;
  int         lq_tail_m;
  word_addr_t sq_addr_m [LSQ_DEPTH];
  data_t      sq_data_m [LSQ_DEPTH];

  tb_clock_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (4)
  ) u_tb_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  lsq_top #(
    .LSQ_DEPTH (LSQ_DEPTH)
  ) u_lsq_top (
    .clock             (clock),
    .reset             (reset),
    .dispatch          (dispatch),
    .dispatch_en       (dispatch_en),
    .store_exec        (store_exec),
    .load_exec         (load_exec),
    .store_retire      (store_retire),
    .load_retire_count (load_retire_count),
    .cache_rd_valid    (cache_rd_valid),
    .cache_rd_data     (cache_rd_data),
    .cache_wr_ack      (cache_wr_ack),
    .dispatch_ready    (dispatch_ready),
    .sq_idx            (sq_idx),
    .lq_idx            (lq_idx),
    .cache_rd          (cache_rd),
    .cache_wr          (cache_wr),
    .store_retired     (store_retired),
    .load_result       (load_result),
    .violation         (violation)
  );

  // Cache answers in the request cycle when the test allows it
  assign cache_rd_valid = cache_ready;
  assign cache_rd_data  = cache_mem[cache_rd.addr[3:0]];

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_index(input idx_t got, input idx_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_cache_rd(input cache_rd_req_t got, input cache_rd_req_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %0t ns: cache read en %b addr %h, expected en %b addr %h",
                         $time, got.rd_en, got.addr, exp.rd_en, exp.addr));
    end
  endtask

  task automatic check_cache_wr(input cache_wr_req_t got, input cache_wr_req_t exp);
    if (got.wr_en !== exp.wr_en || (exp.wr_en && got !== exp)) begin
      stop_run($sformatf("ERROR %0t ns: cache write en %b addr %h data %h, expected %b %h %h",
                         $time, got.wr_en, got.addr, got.data, exp.wr_en, exp.addr, exp.data));
    end
  endtask

  task automatic check_load_result(input load_result_t got, input load_result_t exp);
    if (got.done !== exp.done || (exp.done && got !== exp)) begin
      stop_run($sformatf("ERROR %0t ns: load result done %b tag %h data %h fwd %b, %s %b %h %h %b",
                         $time, got.done, got.tag, got.data, got.forwarded, "expected",
                         exp.done, exp.tag, exp.data, exp.forwarded));
    end
  endtask

  task automatic check_violation(input violation_t got, input violation_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      stop_run($sformatf("ERROR %0t ns: violation %b lq %0d pc %h, expected %b lq %0d pc %h",
                         $time, got.valid, got.lq_idx, got.pc, exp.valid, exp.lq_idx, exp.pc));
    end
  endtask

  function automatic int ring_count(input int head, input int tail);
    return (tail - head + LSQ_DEPTH) % LSQ_DEPTH;
  endfunction

  task automatic idle_inputs();
    dispatch          = '0;
    dispatch_en       = 1'b0;
    store_exec        = '0;
    load_exec         = '0;
    store_retire      = 1'b0;
    load_retire_count = '0;
    cache_wr_ack      = 1'b0;
    cache_ready       = 1'b0;
  endtask

  `include "lsq_tests.svh"

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    idle_inputs();
    void'($urandom(SEED));
    for (int i = 0; i < CACHE_WORDS; i++) begin
      cache_mem[i] = {$urandom, $urandom};
    end
    sq_head_m = 0;
    sq_tail_m = 0;
    lq_head_m = 0;
    lq_tail_m = 0;
    @(negedge reset);
    dispatch_and_fill_rings();
    forward_from_older_store();
    read_through_cache();
    retire_stores_in_order();
    flag_ordering_violation();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
hdl/lsq_mem_pkg.sv
hdl/lsq_ctrl_pkg.sv
hdl/store_forward.sv
hdl/store_queue.sv
hdl/load_order_check.sv
hdl/load_queue.sv
hdl/lsq_top.sv
testbench/tb_clock_gen.sv
testbench/lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb -f vlog.f

sim_out=$(./obj_dir/Vlsq_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
else
  exit 1
fi
